// ==== verilog/axis_route_consts.svh ====
`ifndef AXIS_ROUTE_CONSTS_SVH
`define AXIS_ROUTE_CONSTS_SVH

// Stream word width.
`define AXIS_DATA_W 32

// Output channels of the router.
`define AXIS_CHANNELS 4

`define AXIS_CHAN_W $clog2(`AXIS_CHANNELS)

// Header layout. Channel field sits in the low bits.
`define AXIS_HDR_CHAN_W 4
`define AXIS_HDR_TAG_W (`AXIS_DATA_W - `AXIS_HDR_CHAN_W)

// Dropped packet counter, wraps.
`define AXIS_DROP_CNT_W 16

`endif

// ==== verilog/axis_route_pkg.sv ====
`include "axis_route_consts.svh"

package axis_route_pkg;

    // Header word as the router sees it.
    typedef struct packed {
        logic [`AXIS_HDR_TAG_W-1:0]  tag;   // Opaque to the router.
        logic [`AXIS_HDR_CHAN_W-1:0] chan;  // Target output.
    } route_hdr_t;

    // One stream word, read as payload or as a route header.
    // The header beat is decoded for routing and still forwarded as data.
    typedef union packed {
        logic [`AXIS_DATA_W-1:0] data;
        route_hdr_t              hdr;
    } axis_word_u;

    // Everything that travels with one beat besides the handshake.
    typedef struct packed {
        axis_word_u word;
        logic       last;
    } axis_beat_t;

endpackage

// ==== verilog/axis_if_demux.sv ====
`timescale 1ns/1ns
`include "axis_route_consts.svh"

module axis_if_demux (
    input  axis_route_pkg::axis_beat_t in_beat,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic                       en,
    input  logic [`AXIS_CHAN_W-1:0]    ctrl,
    output axis_route_pkg::axis_beat_t out_beat  [`AXIS_CHANNELS],
    output logic                       out_valid [`AXIS_CHANNELS],
    input  logic                       out_ready [`AXIS_CHANNELS]
);

    always_comb begin
        for (int i = 0; i < `AXIS_CHANNELS; i++) begin
            out_valid[i] = 1'b0;
            out_beat[i]  = '0;
        end

        // Disabled route swallows the input at full rate.
        in_ready = 1'b1;

        if (en) begin
            out_valid[ctrl] = in_valid;
            out_beat[ctrl]  = in_beat;
            in_ready        = out_ready[ctrl];
        end
    end

endmodule

// ==== verilog/axis_route_ctrl.sv ====
`timescale 1ns/1ns
`include "axis_route_consts.svh"

module axis_route_ctrl (
    input  logic                         aclk,
    input  logic                         rst_n,
    input  axis_route_pkg::axis_beat_t   beat,
    input  logic                         valid,
    input  logic                         ready,
    output logic                         en,
    output logic [`AXIS_CHAN_W-1:0]      ctrl,
    output logic [`AXIS_DROP_CNT_W-1:0]  drop_count
);

    logic                    pkt_start;  // Next transfer is a header.
    logic                    en_q;
    logic [`AXIS_CHAN_W-1:0] ctrl_q;
    logic                    hdr_en;
    logic [`AXIS_CHAN_W-1:0] hdr_ctrl;
    logic                    xfer;

    assign xfer = valid && ready;

    // Route straight from the header view of the current word.
    assign hdr_en   = beat.word.hdr.chan < `AXIS_CHANNELS;
    assign hdr_ctrl = beat.word.hdr.chan[`AXIS_CHAN_W-1:0];

    assign en   = pkt_start ? hdr_en   : en_q;
    assign ctrl = pkt_start ? hdr_ctrl : ctrl_q;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            pkt_start <= 1'b1;
            en_q      <= 1'b0;
            ctrl_q    <= '0;
        end else if (xfer) begin
            if (pkt_start && !beat.last) begin
                en_q      <= hdr_en;     // Held until last.
                ctrl_q    <= hdr_ctrl;
                pkt_start <= 1'b0;
            end else if (!pkt_start && beat.last) begin
                pkt_start <= 1'b1;
            end
        end
    end

    // One count per dropped packet, taken on its header.
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            drop_count <= '0;
        end else if (xfer && pkt_start && !hdr_en) begin
            drop_count <= drop_count + 1'b1;
        end
    end

    // Mid-packet the route must not move, up to and including the last beat.
    property p_route_held;
        @(posedge aclk) disable iff (!rst_n)
            !pkt_start |=> $stable({en_q, ctrl_q});
    endproperty

    a_route_held: assert property (p_route_held)
        else $error("route changed inside a packet");

endmodule

// ==== verilog/axis_skid_buffer.sv ====
`timescale 1ns/1ns
`include "axis_route_consts.svh"

module axis_skid_buffer (
    input  logic                       aclk,
    input  logic                       rst_n,
    input  axis_route_pkg::axis_beat_t in_beat,
    input  logic                       in_valid,
    output logic                       in_ready,
    output axis_route_pkg::axis_beat_t out_beat,
    output logic                       out_valid,
    input  logic                       out_ready
);

    axis_route_pkg::axis_beat_t skid_beat;
    axis_route_pkg::axis_beat_t out_beat_d;
    axis_route_pkg::axis_beat_t skid_beat_d;
    logic                       skid_valid;
    logic                       out_valid_d;
    logic                       skid_valid_d;
    logic                       in_xfer;

    assign in_xfer = in_valid && in_ready;

    always_comb begin
        out_valid_d  = out_valid;
        out_beat_d   = out_beat;
        skid_valid_d = skid_valid;
        skid_beat_d  = skid_beat;

        if (!out_valid || out_ready) begin
            if (skid_valid) begin
                // Drain the spare entry first. No input can arrive now.
                out_valid_d  = 1'b1;
                out_beat_d   = skid_beat;
                skid_valid_d = 1'b0;
            end else begin
                out_valid_d = in_xfer;
                if (in_xfer) begin
                    out_beat_d = in_beat;
                end
            end
        end else if (in_xfer) begin
            skid_valid_d = 1'b1;   // Output stalled, park the beat.
            skid_beat_d  = in_beat;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            out_valid  <= out_valid_d;
            skid_valid <= skid_valid_d;
            in_ready   <= !skid_valid_d;  // Low only with both entries full.
        end
    end

    always_ff @(posedge aclk) begin
        out_beat  <= out_beat_d;
        skid_beat <= skid_beat_d;
    end

    // A stalled beat holds until the sink takes it.
    property p_out_stable;
        @(posedge aclk) disable iff (!rst_n)
            out_valid && !out_ready |=> out_valid && $stable(out_beat);
    endproperty

    a_out_stable: assert property (p_out_stable)
        else $error("output beat changed while stalled");

endmodule

// ==== verilog/axis_router.sv ====
`timescale 1ns/1ns
`include "axis_route_consts.svh"

module axis_router (
    input  logic                        aclk,
    input  logic                        rst_n,
    input  axis_route_pkg::axis_beat_t  s_beat,
    input  logic                        s_valid,
    output logic                        s_ready,
    output axis_route_pkg::axis_beat_t  m_beat  [`AXIS_CHANNELS],
    output logic                        m_valid [`AXIS_CHANNELS],
    input  logic                        m_ready [`AXIS_CHANNELS],
    output logic [`AXIS_DROP_CNT_W-1:0] drop_count
);

    logic                       route_en;
    logic [`AXIS_CHAN_W-1:0]    route_ctrl;
    axis_route_pkg::axis_beat_t dmx_beat  [`AXIS_CHANNELS];
    logic                       dmx_valid [`AXIS_CHANNELS];
    logic                       dmx_ready [`AXIS_CHANNELS];

    axis_route_ctrl route_ctrl_i (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .beat       (s_beat),
        .valid      (s_valid),
        .ready      (s_ready),
        .en         (route_en),
        .ctrl       (route_ctrl),
        .drop_count (drop_count)
    );

    axis_if_demux demux_i (
        .in_beat   (s_beat),
        .in_valid  (s_valid),
        .in_ready  (s_ready),
        .en        (route_en),
        .ctrl      (route_ctrl),
        .out_beat  (dmx_beat),
        .out_valid (dmx_valid),
        .out_ready (dmx_ready)
    );

    // Registered outputs, one slice per channel.
    for (genvar g = 0; g < `AXIS_CHANNELS; g++) begin : gen_out
        axis_skid_buffer skid_i (
            .aclk      (aclk),
            .rst_n     (rst_n),
            .in_beat   (dmx_beat[g]),
            .in_valid  (dmx_valid[g]),
            .in_ready  (dmx_ready[g]),
            .out_beat  (m_beat[g]),
            .out_valid (m_valid[g]),
            .out_ready (m_ready[g])
        );
    end

endmodule

// ==== tests/axis_router_model.svh ====
`ifndef AXIS_ROUTER_MODEL_SVH
`define AXIS_ROUTER_MODEL_SVH

// Channel number that stands for a dropped packet.
localparam int ROUTE_DROP = -1;

localparam int EXP_AW = 12;

// Expected beats, one FIFO per output channel.
axis_route_pkg::axis_beat_t exp_mem [`AXIS_CHANNELS][2**EXP_AW];
int                         exp_wr  [`AXIS_CHANNELS];
int                         exp_rd  [`AXIS_CHANNELS];

// The low nibble of a header names the output. Numbers past the last port drop the packet.
function automatic int route_of(input logic [`AXIS_DATA_W-1:0] word);
    int chan;
    chan = int'(word[`AXIS_HDR_CHAN_W-1:0]);
    if (chan < `AXIS_CHANNELS) begin
        return chan;
    end
    return ROUTE_DROP;
endfunction

task automatic push_expected(input int ch, input axis_route_pkg::axis_beat_t b);
    exp_mem[ch][exp_wr[ch][EXP_AW-1:0]] = b;
    exp_wr[ch]++;
endtask

task automatic pop_expected(input int ch, output axis_route_pkg::axis_beat_t b,
                            output bit found);
    found = exp_rd[ch] != exp_wr[ch];
    b     = '0;
    if (found) begin
        b = exp_mem[ch][exp_rd[ch][EXP_AW-1:0]];
        exp_rd[ch]++;
    end
endtask

// Beats sent but not yet seen on any output.
function automatic int pending_beats();
    int total;
    total = 0;
    for (int c = 0; c < `AXIS_CHANNELS; c++) begin
        total += exp_wr[c] - exp_rd[c];
    end
    return total;
endfunction

`endif

// ==== tests/axis_router_tb.sv ====
`timescale 1ns/1ns
`include "axis_route_consts.svh"

module axis_router_tb;

    localparam int SEED            = 88026;
    localparam int CLK_NS          = 10;
    localparam int FAST_PACKETS    = 40;
    localparam int SLOW_PACKETS    = 160;
    localparam int MAX_BEATS       = 6;
    localparam int CYCLES_PER_BEAT = 8;
    localparam int MARGIN_CYCLES   = 200;
    localparam int WATCHDOG_CYCLES =
        (FAST_PACKETS + SLOW_PACKETS) * MAX_BEATS * CYCLES_PER_BEAT + MARGIN_CYCLES;

    logic                        aclk;
    logic                        rst_n;
    axis_route_pkg::axis_beat_t  s_beat;
    logic                        s_valid;
    logic                        s_ready;
    axis_route_pkg::axis_beat_t  m_beat  [`AXIS_CHANNELS];
    logic                        m_valid [`AXIS_CHANNELS];
    logic                        m_ready [`AXIS_CHANNELS];
    logic [`AXIS_DROP_CNT_W-1:0] drop_count;

    integer stim_seed  = SEED;
    integer ready_seed = SEED + 1;
    string  test_name  = "reset";
    bit     fast_mode  = 1'b1;  // All sinks open.
    bit     drain_mode = 1'b0;
    bit     rate_check = 1'b0;  // s_ready must stay high.
    int     err_value  = 0;
    int     err_other  = 0;
    int     exp_drops  = 0;

    `include "axis_router_model.svh"

    axis_router axis_router_i (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .s_beat     (s_beat),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .m_beat     (m_beat),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .drop_count (drop_count)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #(CLK_NS / 2) aclk = ~aclk;
        end
    end

    // Sinks stall at random outside the full-rate and drain phases.
    initial begin
        for (int c = 0; c < `AXIS_CHANNELS; c++) begin
            m_ready[c] = 1'b1;
        end
        forever begin
            @(negedge aclk);
            for (int c = 0; c < `AXIS_CHANNELS; c++) begin
                if (fast_mode || drain_mode) begin
                    m_ready[c] = 1'b1;
                end else begin
                    m_ready[c] = ($random(ready_seed) % 4) != 0;
                end
            end
        end
    end

    task automatic check_output(input int ch, input axis_route_pkg::axis_beat_t got);
        axis_route_pkg::axis_beat_t want;
        bit                         found;
        pop_expected(ch, want, found);
        if (!found) begin
            err_other++;
            $display("Unexpected beat %h on channel %0d at %0t ns", got, ch, $time);
        end else if (got !== want) begin
            err_value++;
            $display("[FAIL] %s ch%0d: expected %h, actual %h", test_name, ch, want, got);
        end
    endtask

    // Output side compare, on every handshake.
    always @(posedge aclk) begin
        if (rst_n) begin
            if (rate_check && !s_ready) begin
                err_other++;
                $display("s_ready low at %0t ns while every output was ready", $time);
            end
            for (int c = 0; c < `AXIS_CHANNELS; c++) begin
                if (m_valid[c] && m_ready[c]) begin
                    check_output(c, m_beat[c]);
                end
            end
        end
    end

    task automatic check_reset_state();
        for (int c = 0; c < `AXIS_CHANNELS; c++) begin
            if (m_valid[c] !== 1'b0) begin
                err_value++;
                $display("[FAIL] %s m_valid[%0d]: expected 0, actual %b",
                         test_name, c, m_valid[c]);
            end
        end
        if (drop_count !== '0) begin
            err_value++;
            $display("[FAIL] %s drop_count: expected 0, actual %0d", test_name, drop_count);
        end
    endtask

    task automatic check_drops();
        if (drop_count !== exp_drops[`AXIS_DROP_CNT_W-1:0]) begin
            err_value++;
            $display("[FAIL] %s drop_count: expected %0d, actual %0d",
                     test_name, exp_drops[`AXIS_DROP_CNT_W-1:0], drop_count);
        end
    endtask

    task automatic idle_cycles(input int n);
        s_valid = 1'b0;
        for (int i = 0; i < n; i++) begin
            s_beat.word.data = $random(stim_seed);  // Junk on an idle bus.
            @(negedge aclk);
        end
    endtask

    // Mostly channels 0 to 3, the rest are drops.
    function automatic logic [`AXIS_DATA_W-1:0] make_header();
        logic [`AXIS_DATA_W-1:0] word;
        logic [31:0]             sel;
        int                      pick;
        word = $random(stim_seed);
        pick = $unsigned($random(stim_seed)) % 8;
        if (pick < 6) begin
            sel = pick % 4;
        end else begin
            sel = 4 + ($unsigned($random(stim_seed)) % 12);
        end
        word[`AXIS_HDR_CHAN_W-1:0] = sel[`AXIS_HDR_CHAN_W-1:0];
        return word;
    endfunction

    task automatic send_beat(input axis_route_pkg::axis_beat_t b, input int ch);
        s_beat  = b;
        s_valid = 1'b1;
        @(posedge aclk);
        while (!s_ready) begin
            @(posedge aclk);
        end
        if (ch != ROUTE_DROP) begin
            push_expected(ch, b);
        end
        @(negedge aclk);
        if (rate_check && ch != ROUTE_DROP) begin
            if (!m_valid[ch] || m_beat[ch] !== b) begin
                err_value++;
                $display("[FAIL] %s ch%0d latency: expected %h, actual %h (valid %b)",
                         test_name, ch, b, m_beat[ch], m_valid[ch]);
            end
        end
    endtask

    task automatic send_packet(input bit gaps);
        axis_route_pkg::axis_beat_t b;
        int                         len;
        int                         ch;
        len         = 1 + ($unsigned($random(stim_seed)) % MAX_BEATS);
        b.word.data = make_header();
        ch          = route_of(b.word.data);
        if (ch == ROUTE_DROP) begin
            exp_drops++;
        end
        for (int i = 0; i < len; i++) begin
            if (i > 0) begin
                b.word.data = $random(stim_seed);  // Follows the header, whatever it decodes to.
            end
            b.last = (i == len - 1);
            if (gaps && ($unsigned($random(stim_seed)) % 4) == 0) begin
                idle_cycles(1 + ($unsigned($random(stim_seed)) % 2));
            end
            send_beat(b, ch);
        end
        idle_cycles($unsigned($random(stim_seed)) % 3);
    endtask

    initial begin
        rst_n   = 1'b0;
        s_valid = 1'b0;
        s_beat  = '0;
        for (int c = 0; c < `AXIS_CHANNELS; c++) begin
            exp_wr[c] = 0;
            exp_rd[c] = 0;
        end
        repeat (3) begin
            @(posedge aclk);
            @(negedge aclk);
            check_reset_state();
        end
        rst_n = 1'b1;
        @(posedge aclk);
        @(negedge aclk);

        test_name  = "throughput";
        rate_check = 1'b1;
        for (int p = 0; p < FAST_PACKETS; p++) begin
            send_packet(1'b0);
        end
        idle_cycles(3);
        check_drops();

        test_name  = "backpressure";
        rate_check = 1'b0;
        fast_mode  = 1'b0;
        for (int p = 0; p < SLOW_PACKETS; p++) begin
            send_packet(1'b1);
        end

        test_name  = "drain";
        drain_mode = 1'b1;
        idle_cycles(1);
        while (pending_beats() != 0) begin
            @(negedge aclk);
        end
        idle_cycles(4);  // Room for a stray beat to show up.
        check_drops();

        $display("Done: %0d value errors, %0d other errors, %0d packets dropped",
                 err_value, err_other, exp_drops);
        if (err_value + err_other == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_NS);
        $display("Timeout: run did not finish within %0d cycles, %0d beats still pending",
                 WATCHDOG_CYCLES, pending_beats());
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== axis_router.f ====
+incdir+verilog
+incdir+tests
verilog/axis_route_pkg.sv
verilog/axis_if_demux.sv
verilog/axis_route_ctrl.sv
verilog/axis_skid_buffer.sv
verilog/axis_router.sv
tests/axis_router_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := axis_router_tb
FILELIST   := axis_router.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := ERRORS FOUND

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
